// File: pgm_beat_pkg.sv
// packet beat format
package pgm_beat_pkg;

	// beat geometry
	localparam int beat_w = 134;
	localparam int pos_w = 2;
	localparam int vbytes_w = 4;
	localparam int payload_w = 128;
	localparam int beat_bytes = 16;

	// position codes in the top two bits
	localparam logic [pos_w-1:0] pos_head = 2'b01;
	localparam logic [pos_w-1:0] pos_mid = 2'b11;
	localparam logic [pos_w-1:0] pos_tail = 2'b10;

	// template store and counter widths
	localparam int tpl_aw = 7;
	localparam int time_w = 32;
	localparam int cnt_w = 64;

	typedef struct packed {
		logic [pos_w-1:0] pos;
		logic [vbytes_w-1:0] vbytes;
		logic [payload_w-1:0] payload;
	} data_view_t;

	// header beat of a control packet
	typedef struct packed {
		logic [pos_w-1:0] pos;
		logic [3:0] spare_nib;
		logic resp;
		logic [2:0] opcode;
		logic [11:0] spare_hi;
		logic [7:0] src_id;
		logic [7:0] dst_id;
		logic [31:0] addr;
		logic [31:0] spare_lo;
		logic [31:0] word;
	} ctrl_view_t;

	typedef union packed {
		data_view_t data;
		ctrl_view_t ctrl;
	} pgm_beat_u;

endpackage

// File: pgm_reg_pkg.sv
// control channel register map
package pgm_reg_pkg;

	// opcodes of the control header
	localparam logic [2:0] op_write = 3'b010;
	localparam logic [2:0] op_read = 3'b001;
	localparam logic [2:0] op_resp = 3'b011;

	// bit 0 is the soft restart
	localparam logic [31:0] reg_ctrl = 32'h0000_0000;
	// current gap count, read only
	localparam logic [31:0] reg_gap_cnt = 32'h0000_0001;
	// gap length in cycles
	localparam logic [31:0] reg_gap = 32'h0001_0001;

	// generated byte counter halves
	localparam logic [31:0] reg_bytes_lo = 32'h0000_0003;
	localparam logic [31:0] reg_bytes_hi = 32'h0000_0004;

	// generated packet counter halves
	localparam logic [31:0] reg_pkts_lo = 32'h0000_0005;
	localparam logic [31:0] reg_pkts_hi = 32'h0000_0006;

	// returned for unmapped addresses
	localparam logic [31:0] rd_filler = 32'hffff_ffff;

endpackage

// File: pgm_frame_fifo.sv
// user beat frame fifo
module pgm_frame_fifo #(
	parameter int fifo_depth = 64
) (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input logic [pgm_beat_pkg::beat_w-1:0] wr_data,
	input logic rd_en,
	output logic [pgm_beat_pkg::beat_w-1:0] rd_data,
	output logic empty
);

	localparam int aw = $clog2(fifo_depth);

	logic [pgm_beat_pkg::beat_w-1:0] mem [0:fifo_depth-1];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [aw:0] count;
	logic full;
	logic do_wr;
	logic do_rd;

	assign empty = (count == '0);
	assign full = (count == (aw+1)'(fifo_depth));
	// writes into a full buffer are lost
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// head beat shown ahead of the pop
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: pgm_template_ram.sv
// template packet store
module pgm_template_ram (
	input logic clk,
	input logic wr_en,
	input logic [pgm_beat_pkg::tpl_aw-1:0] wr_addr,
	input logic [pgm_beat_pkg::beat_w-1:0] wr_data,
	input logic rd_en,
	input logic [pgm_beat_pkg::tpl_aw-1:0] rd_addr,
	output logic [pgm_beat_pkg::beat_w-1:0] rd_data
);

	localparam int depth = 1 << pgm_beat_pkg::tpl_aw;

	logic [pgm_beat_pkg::beat_w-1:0] mem [0:depth-1];

	// loaded from outside while the generator is idle
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read, block ram style
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

// File: pgm_gen_fsm.sv
// generator scheduler
module pgm_gen_fsm (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [pgm_beat_pkg::time_w-1:0] run_time,
	input pgm_beat_pkg::pgm_beat_u fifo_beat,
	input logic fifo_empty,
	output logic fifo_pop,
	output logic ram_rd,
	output logic [pgm_beat_pkg::tpl_aw-1:0] ram_addr,
	input pgm_beat_pkg::pgm_beat_u ram_beat,
	input logic [31:0] gap_len,
	input logic soft_restart,
	output logic [pgm_beat_pkg::beat_w-1:0] out_data,
	output logic out_data_wr,
	output logic [31:0] gap_cnt,
	output logic [pgm_beat_pkg::cnt_w-1:0] byte_cnt,
	output logic [pgm_beat_pkg::cnt_w-1:0] pkt_cnt
);

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_forward = 3'd1;
	localparam logic [2:0] st_prime = 3'd2;
	localparam logic [2:0] st_replay = 3'd3;
	localparam logic [2:0] st_gap = 3'd4;
	localparam logic [2:0] st_insert = 3'd5;
	localparam logic [2:0] st_discard = 3'd6;
	localparam logic [2:0] st_finished = 3'd7;

	logic [2:0] state;
	logic prime_step;
	logic disc_to_gap;
	logic [pgm_beat_pkg::time_w-1:0] run_limit;
	logic [pgm_beat_pkg::time_w-1:0] elapsed;
	logic fifo_head;
	logic fifo_tail;
	logic ram_tail;
	logic time_up;
	logic user_beat;
	logic [pgm_beat_pkg::cnt_w-1:0] add_bytes;

	assign fifo_head = (fifo_beat.data.pos == pgm_beat_pkg::pos_head);
	assign fifo_tail = (fifo_beat.data.pos == pgm_beat_pkg::pos_tail);
	assign ram_tail = (ram_beat.data.pos == pgm_beat_pkg::pos_tail);
	assign time_up = (elapsed >= run_limit);

	// full beats count 16 bytes, the tail its own field
	assign add_bytes = ram_tail ?
		{{(pgm_beat_pkg::cnt_w - pgm_beat_pkg::vbytes_w){1'b0}}, ram_beat.data.vbytes} :
		pgm_beat_pkg::cnt_w'(pgm_beat_pkg::beat_bytes);

	// **********************************************************************
	// fifo pop and user beat selection
	// **********************************************************************

	// start wins over a waiting user packet
	always_comb begin
		case (state)
			st_idle: fifo_pop = !fifo_empty && !start;
			st_forward, st_gap, st_insert, st_discard: fifo_pop = !fifo_empty;
			default: fifo_pop = 1'b0;
		endcase
	end

	// popped beats that go out, as opposed to discarded ones
	assign user_beat = fifo_pop && (state == st_forward || state == st_insert ||
		((state == st_idle || state == st_gap) && fifo_head));

	always_ff @(posedge clk) begin
		if (state == st_replay)
			out_data <= ram_beat;
		else if (fifo_pop)
			out_data <= fifo_beat;
	end

	// **********************************************************************
	// state machine
	// **********************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			prime_step <= 1'b0;
			disc_to_gap <= 1'b0;
			ram_rd <= 1'b0;
			ram_addr <= '0;
			run_limit <= '0;
			elapsed <= '0;
			gap_cnt <= '0;
			byte_cnt <= '0;
			pkt_cnt <= '0;
			out_data_wr <= 1'b0;
		end else begin
			out_data_wr <= user_beat || (state == st_replay);
			if (state != st_idle && state != st_forward && state != st_finished)
				elapsed <= elapsed + 1'b1;
			if (state == st_gap || state == st_insert)
				gap_cnt <= gap_cnt + 1'b1;

			case (state)
				st_idle: begin
					if (start) begin
						run_limit <= run_time;
						elapsed <= '0;
						gap_cnt <= '0;
						byte_cnt <= '0;
						pkt_cnt <= '0;
						prime_step <= 1'b0;
						state <= st_prime;
					end else if (fifo_pop) begin
						disc_to_gap <= 1'b0;
						// a lone stray tail is dropped right here
						if (fifo_head)
							state <= st_forward;
						else if (!fifo_tail)
							state <= st_discard;
					end
				end
				st_forward: begin
					if (fifo_pop && fifo_tail)
						state <= st_idle;
				end
				// two reads ahead so ram_beat lines up with replay
				st_prime: begin
					ram_rd <= 1'b1;
					prime_step <= 1'b1;
					if (!prime_step) begin
						ram_addr <= '0;
					end else begin
						ram_addr <= ram_addr + 1'b1;
						state <= st_replay;
					end
				end
				st_replay: begin
					ram_addr <= ram_addr + 1'b1;
					byte_cnt <= byte_cnt + add_bytes;
					if (ram_tail) begin
						ram_rd <= 1'b0;
						pkt_cnt <= pkt_cnt + 1'b1;
						gap_cnt <= '0;
						state <= time_up ? st_finished : st_gap;
					end
				end
				st_gap: begin
					if (fifo_pop) begin
						disc_to_gap <= 1'b1;
						if (fifo_head)
							state <= st_insert;
						else if (!fifo_tail)
							state <= st_discard;
					end else if (time_up) begin
						state <= st_finished;
					end else if (gap_cnt >= gap_len) begin
						prime_step <= 1'b0;
						state <= st_prime;
					end
				end
				st_insert: begin
					if (fifo_pop && fifo_tail)
						state <= st_gap;
				end
				st_discard: begin
					if (fifo_pop && fifo_tail)
						state <= disc_to_gap ? st_gap : st_idle;
				end
				st_finished: begin
					if (soft_restart)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: pgm_cfg_regs.sv
// control packet register block
module pgm_cfg_regs #(
	parameter logic [7:0] self_mid = 8'd62
) (
	input logic clk,
	input logic rst_n,
	input pgm_beat_pkg::pgm_beat_u cin_data,
	input logic cin_data_wr,
	output logic [pgm_beat_pkg::beat_w-1:0] cout_data,
	output logic cout_data_wr,
	output logic [31:0] gap_len,
	output logic soft_restart,
	input logic [31:0] gap_cnt,
	input logic [pgm_beat_pkg::cnt_w-1:0] byte_cnt,
	input logic [pgm_beat_pkg::cnt_w-1:0] pkt_cnt
);

	logic is_head;
	logic is_tail;
	logic for_me;
	logic wr_hit;
	logic rd_hit;
	// set from a write header until its tail
	logic write_flag;
	logic [31:0] rd_val;
	pgm_beat_pkg::pgm_beat_u resp_beat;

	assign is_head = cin_data_wr && (cin_data.ctrl.pos == pgm_beat_pkg::pos_head);
	assign is_tail = cin_data_wr && (cin_data.ctrl.pos == pgm_beat_pkg::pos_tail);
	assign for_me = (cin_data.ctrl.dst_id == self_mid);
	assign wr_hit = is_head && for_me && (cin_data.ctrl.opcode == pgm_reg_pkg::op_write);
	assign rd_hit = is_head && for_me && (cin_data.ctrl.opcode == pgm_reg_pkg::op_read);

	// **********************************************************************
	// read mux and response header
	// **********************************************************************

	always_comb begin
		case (cin_data.ctrl.addr)
			pgm_reg_pkg::reg_ctrl: rd_val = {31'b0, soft_restart};
			pgm_reg_pkg::reg_gap_cnt: rd_val = gap_cnt;
			pgm_reg_pkg::reg_gap: rd_val = gap_len;
			pgm_reg_pkg::reg_bytes_lo: rd_val = byte_cnt[31:0];
			pgm_reg_pkg::reg_bytes_hi: rd_val = byte_cnt[63:32];
			pgm_reg_pkg::reg_pkts_lo: rd_val = pkt_cnt[31:0];
			pgm_reg_pkg::reg_pkts_hi: rd_val = pkt_cnt[63:32];
			default: rd_val = pgm_reg_pkg::rd_filler;
		endcase
	end

	// ids swap so the answer heads back to the requester
	always_comb begin
		resp_beat = cin_data;
		resp_beat.ctrl.resp = 1'b1;
		resp_beat.ctrl.opcode = pgm_reg_pkg::op_resp;
		resp_beat.ctrl.src_id = cin_data.ctrl.dst_id;
		resp_beat.ctrl.dst_id = cin_data.ctrl.src_id;
		resp_beat.ctrl.word = rd_val;
	end

	// **********************************************************************
	// registers and control output
	// **********************************************************************

	always_ff @(posedge clk) begin
		cout_data <= rd_hit ? resp_beat : cin_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cout_data_wr <= 1'b0;
			write_flag <= 1'b0;
			gap_len <= '0;
			soft_restart <= 1'b0;
		end else begin
			// our own writes are absorbed, header and tail
			cout_data_wr <= cin_data_wr && !wr_hit && !(is_tail && write_flag);
			if (is_head)
				write_flag <= wr_hit;
			else if (is_tail)
				write_flag <= 1'b0;
			if (wr_hit) begin
				case (cin_data.ctrl.addr)
					pgm_reg_pkg::reg_ctrl: soft_restart <= cin_data.ctrl.word[0];
					pgm_reg_pkg::reg_gap: gap_len <= cin_data.ctrl.word;
					default: gap_len <= gap_len;
				endcase
			end
		end
	end

endmodule

// File: pgm_rd_top.sv
// packet generator read side
module pgm_rd_top #(
	parameter logic [7:0] self_mid = 8'd62,
	parameter int fifo_depth = 64
) (
	input logic clk,
	input logic rst_n,
	input logic [pgm_beat_pkg::beat_w-1:0] in_data,
	input logic in_data_wr,
	output logic [pgm_beat_pkg::beat_w-1:0] out_data,
	output logic out_data_wr,
	input logic tpl_wr,
	input logic [pgm_beat_pkg::tpl_aw-1:0] tpl_addr,
	input logic [pgm_beat_pkg::beat_w-1:0] tpl_data,
	input logic start,
	input logic [pgm_beat_pkg::time_w-1:0] run_time,
	input logic [pgm_beat_pkg::beat_w-1:0] cin_data,
	input logic cin_data_wr,
	output logic [pgm_beat_pkg::beat_w-1:0] cout_data,
	output logic cout_data_wr
);

	// fifo and ram to scheduler
	logic [pgm_beat_pkg::beat_w-1:0] fifo_beat;
	logic fifo_empty;
	logic fifo_pop;
	logic ram_rd;
	logic [pgm_beat_pkg::tpl_aw-1:0] ram_addr;
	logic [pgm_beat_pkg::beat_w-1:0] ram_beat;

	// scheduler and register block
	logic [31:0] gap_len;
	logic soft_restart;
	logic [31:0] gap_cnt;
	logic [pgm_beat_pkg::cnt_w-1:0] byte_cnt;
	logic [pgm_beat_pkg::cnt_w-1:0] pkt_cnt;

	// **********************************************************************
	// data path
	// **********************************************************************

	pgm_frame_fifo #(
		.fifo_depth(fifo_depth)
	) u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(in_data_wr),
		.wr_data(in_data),
		.rd_en(fifo_pop),
		.rd_data(fifo_beat),
		.empty(fifo_empty)
	);

	pgm_template_ram u_ram (
		.clk(clk),
		.wr_en(tpl_wr),
		.wr_addr(tpl_addr),
		.wr_data(tpl_data),
		.rd_en(ram_rd),
		.rd_addr(ram_addr),
		.rd_data(ram_beat)
	);

	pgm_gen_fsm u_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.run_time(run_time),
		.fifo_beat(fifo_beat),
		.fifo_empty(fifo_empty),
		.fifo_pop(fifo_pop),
		.ram_rd(ram_rd),
		.ram_addr(ram_addr),
		.ram_beat(ram_beat),
		.gap_len(gap_len),
		.soft_restart(soft_restart),
		.out_data(out_data),
		.out_data_wr(out_data_wr),
		.gap_cnt(gap_cnt),
		.byte_cnt(byte_cnt),
		.pkt_cnt(pkt_cnt)
	);

	// **********************************************************************
	// control channel
	// **********************************************************************

	pgm_cfg_regs #(
		.self_mid(self_mid)
	) u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.cin_data(cin_data),
		.cin_data_wr(cin_data_wr),
		.cout_data(cout_data),
		.cout_data_wr(cout_data_wr),
		.gap_len(gap_len),
		.soft_restart(soft_restart),
		.gap_cnt(gap_cnt),
		.byte_cnt(byte_cnt),
		.pkt_cnt(pkt_cnt)
	);

endmodule

// File: tb_pgm_rd_sva.sv
// output protocol assertions
module tb_pgm_rd_sva (
	input logic clk,
	input logic rst_n,
	input logic [pgm_beat_pkg::beat_w-1:0] out_data,
	input logic out_data_wr,
	input logic cout_data_wr
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;
	logic after_tail;
	logic [pgm_beat_pkg::pos_w-1:0] out_pos;

	assign out_pos = out_data[pgm_beat_pkg::beat_w-1 -: pgm_beat_pkg::pos_w];

	// last output beat was a tail, or nothing sent yet
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			after_tail <= 1'b1;
		else if (out_data_wr)
			after_tail <= (out_pos == pgm_beat_pkg::pos_tail);
	end

	a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_data_wr)
		else begin
			$error("out_data_wr high in the first cycle after reset release");
			fail_cnt++;
		end

	a_head_after_tail: assert property (@(posedge clk) disable iff (!rst_n)
		(out_data_wr && after_tail) |-> (out_pos == pgm_beat_pkg::pos_head))
		else begin
			$error("output beat after a tail is not a head beat");
			fail_cnt++;
		end

	a_cout_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !$rose(cout_data_wr))
		else begin
			$error("cout_data_wr rose while reset was asserted");
			fail_cnt++;
		end

endmodule

bind pgm_rd_top tb_pgm_rd_sva u_sva (
	.clk(clk),
	.rst_n(rst_n),
	.out_data(out_data),
	.out_data_wr(out_data_wr),
	.cout_data_wr(cout_data_wr)
);

// File: tb_pgm_rd.sv
// packet generator read side testbench
module tb_pgm_rd;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int bw = pgm_beat_pkg::beat_w;
	localparam logic [7:0] self_mid = 8'd62;
	localparam int n_user = 6;
	localparam int max_len = 6;
	localparam int max_gap = 15;
	// cycle budget per phase
	localparam int user_cycles = (n_user + 3) * 2 * (max_len + 4);
	localparam int ctrl_cycles = 12 * 8;
	localparam int run_cycles = 2 * 4 * (max_len + max_gap + 3);
	localparam int limit_cycles = user_cycles + ctrl_cycles + run_cycles + 200;

	logic clk;
	logic rst_n;
	logic [bw-1:0] in_data;
	logic in_data_wr;
	logic [bw-1:0] out_data;
	logic out_data_wr;
	logic tpl_wr;
	logic [pgm_beat_pkg::tpl_aw-1:0] tpl_addr;
	logic [bw-1:0] tpl_data;
	logic start;
	logic [pgm_beat_pkg::time_w-1:0] run_time;
	logic [bw-1:0] cin_data;
	logic cin_data_wr;
	logic [bw-1:0] cout_data;
	logic cout_data_wr;

	logic [15:0] lfsr;
	logic [bw-1:0] exp_q [$];
	logic [bw-1:0] cexp_q [$];
	logic [bw-1:0] cur_pkt [$];
	logic [bw-1:0] tpl [0:7];
	int tlen;
	int tsize;
	int gap;
	int rt;
	int run_start;
	int up0;
	int seen;
	int cycle;
	int quiet;
	int beats_seen;
	int copies;
	int user_pkts;
	int copies_at_user;
	int checks;
	int errors;
	string test_name;

	pgm_rd_top #(
		.self_mid(self_mid),
		.fifo_depth(64)
	) dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(in_data),
		.in_data_wr(in_data_wr),
		.out_data(out_data),
		.out_data_wr(out_data_wr),
		.tpl_wr(tpl_wr),
		.tpl_addr(tpl_addr),
		.tpl_data(tpl_data),
		.start(start),
		.run_time(run_time),
		.cin_data(cin_data),
		.cin_data_wr(cin_data_wr),
		.cout_data(cout_data),
		.cout_data_wr(cout_data_wr)
	);

	always #2 clk = ~clk;

	// ******************************************************************
	// random source and beat builders
	// ******************************************************************

	// taps 16 14 13 11, one step per bit
	function automatic logic [bw-1:0] rand_bits(input int n);
		logic [bw-1:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[bw-2:0], fb};
		end
		return r;
	endfunction

	// a bad packet opens with a middle beat
	function automatic logic [bw-1:0] make_beat(input int i, input int len, input bit bad);
		pgm_beat_pkg::pgm_beat_u b;
		b = rand_bits(bw);
		if (i == len - 1)
			b.data.pos = pgm_beat_pkg::pos_tail;
		else if (i == 0 && !bad)
			b.data.pos = pgm_beat_pkg::pos_head;
		else
			b.data.pos = pgm_beat_pkg::pos_mid;
		return b;
	endfunction

	function automatic pgm_beat_pkg::pgm_beat_u ctrl_head(input logic [2:0] op,
		input logic [7:0] dst, input logic [31:0] addr, input logic [31:0] word);
		pgm_beat_pkg::pgm_beat_u b;
		b = rand_bits(bw);
		b.ctrl.pos = pgm_beat_pkg::pos_head;
		b.ctrl.resp = 1'b0;
		b.ctrl.opcode = op;
		b.ctrl.dst_id = dst;
		b.ctrl.addr = addr;
		b.ctrl.word = word;
		return b;
	endfunction

	function automatic pgm_beat_pkg::pgm_beat_u ctrl_tail();
		pgm_beat_pkg::pgm_beat_u b;
		b = rand_bits(bw);
		b.ctrl.pos = pgm_beat_pkg::pos_tail;
		return b;
	endfunction

	// ******************************************************************
	// checks and result
	// ******************************************************************

	task automatic check_beat(input logic [bw-1:0] exp, input logic [bw-1:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Mismatch in %s: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error in %s: %s", test_name, what);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, dut.u_sva.fail_cnt);
		if (errors == 0 && dut.u_sva.fail_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// a packet equal to the template is a copy, anything else a user packet
	task automatic take_packet();
		logic is_copy;
		logic [bw-1:0] e;
		is_copy = (cur_pkt.size() == tlen);
		foreach (cur_pkt[i]) begin
			if (is_copy && cur_pkt[i] !== tpl[i])
				is_copy = 1'b0;
		end
		if (is_copy) begin
			checks++;
			copies++;
		end else begin
			user_pkts++;
			copies_at_user = copies;
			foreach (cur_pkt[i]) begin
				check_true(exp_q.size() != 0, "output beat arrived with nothing expected");
				if (exp_q.size() != 0) begin
					e = exp_q.pop_front();
					check_beat(e, cur_pkt[i]);
				end
			end
		end
		cur_pkt.delete();
	endtask

	// outputs are registered, so they are read on the falling edge
	always @(negedge clk) begin : monitor
		logic [bw-1:0] e;
		if (out_data_wr == 1'b1) begin
			quiet = 0;
			beats_seen++;
			cur_pkt.push_back(out_data);
			if (out_data[bw-1 -: pgm_beat_pkg::pos_w] == pgm_beat_pkg::pos_tail)
				take_packet();
		end else begin
			quiet++;
		end
		if (cout_data_wr == 1'b1) begin
			check_true(cexp_q.size() != 0, "control beat arrived with nothing expected");
			if (cexp_q.size() != 0) begin
				e = cexp_q.pop_front();
				check_beat(e, cout_data);
			end
		end
	end

	always @(negedge clk) begin
		cycle++;
		if (cycle >= limit_cycles) begin
			errors++;
			$display("Error: run did not complete within %0d cycles", limit_cycles);
			finish_run();
		end
	end

	// ******************************************************************
	// stimulus tasks
	// ******************************************************************

	task automatic send_user(input bit bad);
		int len;
		logic [bw-1:0] b;
		len = 2 + int'(rand_bits(8)) % 5;
		for (int i = 0; i < len; i++) begin
			b = make_beat(i, len, bad);
			if (!bad)
				exp_q.push_back(b);
			@(posedge clk);
			in_data <= b;
			in_data_wr <= 1'b1;
		end
		@(posedge clk);
		in_data_wr <= 1'b0;
	endtask

	task automatic send_ctrl(input logic [bw-1:0] h, input logic [bw-1:0] t);
		@(posedge clk);
		cin_data <= h;
		cin_data_wr <= 1'b1;
		@(posedge clk);
		cin_data <= t;
		@(posedge clk);
		cin_data_wr <= 1'b0;
	endtask

	task automatic ctrl_write(input logic [31:0] addr, input logic [31:0] val);
		send_ctrl(ctrl_head(pgm_reg_pkg::op_write, self_mid, addr, val), ctrl_tail());
	endtask

	// response: resp bit, op_resp, ids swapped, register value
	task automatic ctrl_read(input logic [31:0] addr, input logic [31:0] val);
		pgm_beat_pkg::pgm_beat_u h;
		pgm_beat_pkg::pgm_beat_u t;
		pgm_beat_pkg::pgm_beat_u e;
		h = ctrl_head(pgm_reg_pkg::op_read, self_mid, addr, 32'(rand_bits(32)));
		t = ctrl_tail();
		e = h;
		e.ctrl.resp = 1'b1;
		e.ctrl.opcode = pgm_reg_pkg::op_resp;
		e.ctrl.src_id = h.ctrl.dst_id;
		e.ctrl.dst_id = h.ctrl.src_id;
		e.ctrl.word = val;
		cexp_q.push_back(e);
		cexp_q.push_back(t);
		send_ctrl(h, t);
	endtask

	// other id passes through untouched
	task automatic ctrl_other_id();
		logic [bw-1:0] h;
		logic [bw-1:0] t;
		h = ctrl_head(pgm_reg_pkg::op_write, self_mid + 8'd1, pgm_reg_pkg::reg_gap,
			32'(rand_bits(32)));
		t = ctrl_tail();
		cexp_q.push_back(h);
		cexp_q.push_back(t);
		send_ctrl(h, t);
	endtask

	task automatic load_template();
		pgm_beat_pkg::pgm_beat_u b;
		tlen = 2 + int'(rand_bits(8)) % 5;
		tsize = 0;
		for (int i = 0; i < tlen; i++) begin
			b = make_beat(i, tlen, 1'b0);
			tsize += (i == tlen - 1) ? int'(b.data.vbytes) : pgm_beat_pkg::beat_bytes;
			tpl[i] = b;
			@(posedge clk);
			tpl_wr <= 1'b1;
			tpl_addr <= i[pgm_beat_pkg::tpl_aw-1:0];
			tpl_data <= b;
		end
		@(posedge clk);
		tpl_wr <= 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || cexp_q.size() != 0 || cur_pkt.size() != 0)
			@(posedge clk);
	endtask

	// ******************************************************************
	// test sequence
	// ******************************************************************

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_data = '0;
		in_data_wr = 1'b0;
		tpl_wr = 1'b0;
		tpl_addr = '0;
		tpl_data = '0;
		start = 1'b0;
		run_time = '0;
		cin_data = '0;
		cin_data_wr = 1'b0;
		lfsr = 16'd46059;
		tlen = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		test_name = "user_forward";
		for (int i = 0; i < n_user; i++)
			send_user(1'b0);
		wait_drain();

		test_name = "malformed_discard";
		send_user(1'b1);
		send_user(1'b0);
		wait_drain();

		test_name = "register_access";
		gap = int'(rand_bits(4));
		ctrl_write(pgm_reg_pkg::reg_gap, 32'(gap));
		ctrl_read(pgm_reg_pkg::reg_gap, 32'(gap));
		ctrl_read(32'h0000_0002, pgm_reg_pkg::rd_filler);
		ctrl_other_id();
		wait_drain();

		test_name = "template_replay";
		load_template();
		rt = 4 * (tlen + gap + 3);
		up0 = user_pkts;
		@(posedge clk);
		run_time <= rt;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		run_start = cycle;
		// lands in the fifo while the first copy plays
		send_user(1'b0);
		while (!(cycle - run_start > rt && quiet > gap + tlen + 8))
			@(posedge clk);
		check_true(copies >= 1, "no template copy was generated");
		test_name = "gap_insert";
		check_true(user_pkts == up0 + 1 && copies_at_user >= 1 && copies > copies_at_user,
			"user packet not placed between two template copies");

		test_name = "statistics";
		seen = beats_seen;
		// held in the fifo until soft restart
		send_user(1'b0);
		ctrl_read(pgm_reg_pkg::reg_pkts_lo, 32'(copies));
		ctrl_read(pgm_reg_pkg::reg_pkts_hi, 32'd0);
		ctrl_read(pgm_reg_pkg::reg_bytes_lo, 32'(copies * tsize));
		ctrl_read(pgm_reg_pkg::reg_bytes_hi, 32'd0);
		while (cexp_q.size() != 0)
			@(posedge clk);

		test_name = "finished_hold";
		repeat (8) @(posedge clk);
		check_true(beats_seen == seen, "output beat appeared before soft restart");
		ctrl_write(pgm_reg_pkg::reg_ctrl, 32'd1);
		wait_drain();
		ctrl_write(pgm_reg_pkg::reg_ctrl, 32'd0);
		repeat (20) @(posedge clk);
		finish_run();
	end

endmodule

// File: compile.f
pgm_beat_pkg.sv
pgm_reg_pkg.sv
pgm_frame_fifo.sv
pgm_template_ram.sv
pgm_gen_fsm.sv
pgm_cfg_regs.sv
pgm_rd_top.sv
tb_pgm_rd_sva.sv
tb_pgm_rd.sv

// File: Makefile
# Verilator build and run of the packet generator testbench

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, result taken from sim.log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pgm_rd -f compile.f -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
